//--- list.f
+incdir+hdl
+incdir+verification
hdl/core_pkg.sv
hdl/instr_buffer.sv
hdl/instr_decode.sv
hdl/issue_dispatch.sv
hdl/reg_file.sv
hdl/alu_lane.sv
hdl/cpu_core.sv
verification/tb_cpu_core.sv

//--- verification/tb_core_model.svh
`ifndef TB_CORE_MODEL_SVH
`define TB_CORE_MODEL_SVH

//////////////////////////////
// in-order reference model
//////////////////////////////

logic [`CORE_XLEN-1:0]    model_regs [32];
core_pkg::retire_t        exp_q [$];       // expected retire order
bit                       exp_dep_q [$];   // reads rd of the instruction just before
logic                     prev_writes;
logic [`CORE_RADDR_W-1:0] prev_rd;

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    exp_q.delete();
    exp_dep_q.delete();
    prev_writes = 1'b0;
    prev_rd     = '0;
endtask

// one instruction in program order
task automatic model_execute(input logic [31:0] ir, input logic [31:0] pc);
    logic [5:0]            opc;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [15:0]           imm;
    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [`CORE_XLEN-1:0] res;
    logic                  is_nop;
    logic                  uses_rs2;
    core_pkg::retire_t     rec;
    opc    = ir[31:26];
    rd     = ir[25:21];
    rs1    = ir[20:16];
    rs2    = ir[15:11];
    imm    = ir[15:0];
    a      = model_regs[rs1];   // entry 0 stays zero
    b      = model_regs[rs2];
    is_nop = 1'b0;
    case (opc)
        core_pkg::OP_ADD:  res = a + b;
        core_pkg::OP_SUB:  res = a - b;
        core_pkg::OP_AND:  res = a & b;
        core_pkg::OP_OR:   res = a | b;
        core_pkg::OP_XOR:  res = a ^ b;
        core_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        core_pkg::OP_ADDI: res = a + {{16{imm[15]}}, imm};
        core_pkg::OP_LUI:  res = {imm, 16'h0000};
        default: begin
            res    = '0;   // nop and unknown codes
            is_nop = 1'b1;
        end
    endcase
    uses_rs2 = (opc != core_pkg::OP_ADDI) && (opc != core_pkg::OP_LUI);
    exp_dep_q.push_back(prev_writes && ((prev_rd == rs1) || (uses_rs2 && (prev_rd == rs2))));
    rec.valid     = 1'b1;
    rec.rd        = rd;
    rec.writes_rd = !is_nop && (rd != 5'd0);
    rec.result    = res;
    rec.pc        = pc;
    exp_q.push_back(rec);
    if (rec.writes_rd) begin
        model_regs[rd] = res;
    end
    model_regs[0] = '0;
    prev_writes   = rec.writes_rd;
    prev_rd       = rd;
endtask

`endif

//--- verification/tb_cpu_core.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_cpu_core;

    localparam int NUM_PAIRS = 400;
    localparam int TIMEOUT   = 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  fetch_valid;
    core_pkg::fetch_pair_t fetch;
    logic                  fetch_ready;
    core_pkg::retire_t     retire_a;
    core_pkg::retire_t     retire_b;

    integer                seed       = 77;
    int                    err_count  = 0;   // wrong values
    int                    fail_count = 0;   // timeouts, ordering, lost or extra retires
    int                    accepted   = 0;
    int                    retired    = 0;
    bit                    timed_out  = 1'b0;
    logic [`CORE_XLEN-1:0] next_pc    = 32'h0000_1000;

    `include "tb_core_model.svh"

    cpu_core u_cpu_core (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_fetch_valid (fetch_valid),
        .i_fetch       (fetch),
        .o_fetch_ready (fetch_ready),
        .o_retire_a    (retire_a),
        .o_retire_b    (retire_b)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_retire(input core_pkg::retire_t got, input string port,
                                output bit dep);
        core_pkg::retire_t exp;
        dep = 1'b0;
        retired++;
        if (exp_q.size() == 0) begin
            fail_count++;
            $display("%s retired pc %h at %0t ns with nothing outstanding", port, got.pc, $time);
        end else begin
            exp = exp_q.pop_front();
            dep = exp_dep_q.pop_front();
            check_value({port, ".result"}, got.result, exp.result);
            check_value({port, ".rd"}, 32'(got.rd), 32'(exp.rd));
            check_value({port, ".writes_rd"}, 32'(got.writes_rd), 32'(exp.writes_rd));
            check_value({port, ".pc"}, got.pc, exp.pc);
        end
    endtask

    //////////////////////////////
    // retire checker and model feed
    //////////////////////////////

    always @(negedge clk) begin : retire_check
        bit dep;
        if (rst_n) begin
            if (retire_a.valid) begin
                check_retire(retire_a, "o_retire_a", dep);
            end
            if (retire_b.valid) begin
                if (!retire_a.valid) begin
                    fail_count++;
                    $display("lane b retired without lane a at %0t ns", $time);
                end
                check_retire(retire_b, "o_retire_b", dep);
                if (retire_a.valid && dep) begin
                    fail_count++;
                    $display("dependent pair retired in one cycle at %0t ns", $time);
                end
            end
            // pair transfers at the coming edge
            if (fetch_valid && fetch_ready) begin
                if (fetch.v1) begin
                    model_execute(fetch.ir1, fetch.pc);
                    accepted++;
                end
                if (fetch.v2) begin
                    model_execute(fetch.ir2, fetch.pc + 32'd4);
                    accepted++;
                end
            end
        end
    end

    function automatic logic [31:0] encode(input logic [5:0] opc, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [15:0] imm);
        return {opc, rd, rs1, imm};
    endfunction

    task automatic make_instr(output logic [31:0] ir);
        logic [5:0]  opc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [15:0] imm;
        int          sel;
        sel = {$random(seed)} % 10;
        case (sel)
            0:       opc = core_pkg::OP_NOP;
            1:       opc = core_pkg::OP_ADD;
            2:       opc = core_pkg::OP_SUB;
            3:       opc = core_pkg::OP_AND;
            4:       opc = core_pkg::OP_OR;
            5:       opc = core_pkg::OP_XOR;
            6:       opc = core_pkg::OP_SLT;
            7:       opc = core_pkg::OP_ADDI;
            8:       opc = core_pkg::OP_LUI;
            default: opc = 6'd45;   // no such opcode
        endcase
        rd  = 5'({$random(seed)} % 8);
        rs1 = 5'({$random(seed)} % 8);
        imm = 16'($random(seed));
        if (opc != core_pkg::OP_ADDI && opc != core_pkg::OP_LUI) begin
            imm[15:11] = 5'({$random(seed)} % 8);   // rs2
        end
        ir = encode(opc, rd, rs1, imm);
    endtask

    // holds the pair until it transfers, returns 1 ns after that edge
    task automatic drive_pair(input core_pkg::fetch_pair_t p);
        int waited;
        waited      = 0;
        fetch       = p;
        fetch_valid = 1'b1;
        @(negedge clk);
        while (!fetch_ready && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!fetch_ready) begin
            timed_out = 1'b1;
            fail_count++;
            $display("fetch port stayed not ready for %0d cycles", TIMEOUT);
        end
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
    endtask

    task automatic send_directed(input logic [31:0] ir1, input logic [31:0] ir2);
        core_pkg::fetch_pair_t p;
        p.pc  = next_pc;
        p.ir1 = ir1;
        p.ir2 = ir2;
        p.v1  = 1'b1;
        p.v2  = 1'b1;
        next_pc = next_pc + 32'd8;
        drive_pair(p);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        while (retired < accepted && waited < TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (retired < accepted) begin
            timed_out = 1'b1;
            fail_count++;
            $display("pipeline did not drain, %0d of %0d retired", retired, accepted);
        end
        #1;
    endtask

    task automatic end_run();
        $display("summary: %0d value errors, %0d other failures, %0d accepted, %0d retired",
                 err_count, fail_count, accepted, retired);
        if (err_count == 0 && fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        core_pkg::fetch_pair_t p;
        logic [31:0]           first_pc;
        int                    waited;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch       = '0;
        model_reset();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("o_fetch_ready", 32'(fetch_ready), 32'd1);
        check_value("o_retire_a.valid", 32'(retire_a.valid), 32'd0);
        check_value("o_retire_b.valid", 32'(retire_b.valid), 32'd0);
        @(posedge clk);
        #1;

        // independent pair into an idle pipeline retires on both lanes together
        first_pc = next_pc;
        send_directed(encode(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'h1234),
                      encode(core_pkg::OP_ADDI, 5'd2, 5'd0, 16'hfffd));
        waited = 0;
        @(negedge clk);
        while (!retire_a.valid && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!retire_a.valid) begin
            timed_out = 1'b1;
            fail_count++;
            $display("first directed pair never retired");
        end else begin
            check_value("o_retire_b.valid", 32'(retire_b.valid), 32'd1);
            check_value("o_retire_a.pc", retire_a.pc, first_pc);
        end
        if (!timed_out) begin
            wait_drain();
        end

        // raw pair, then writes to r0 read back
        if (!timed_out) begin
            send_directed(encode(core_pkg::OP_ADDI, 5'd3, 5'd0, 16'h0009),
                          encode(core_pkg::OP_ADD, 5'd4, 5'd3, {5'd3, 11'd0}));
            wait_drain();
        end
        if (!timed_out) begin
            send_directed(encode(core_pkg::OP_ADDI, 5'd0, 5'd0, 16'h0055),
                          encode(core_pkg::OP_ADD, 5'd5, 5'd0, {5'd1, 11'd0}));
            wait_drain();
        end

        for (int i = 0; i < NUM_PAIRS && !timed_out; i++) begin
            p.pc = next_pc;
            next_pc = next_pc + 32'd8;
            make_instr(p.ir1);
            make_instr(p.ir2);
            p.v1 = 1'b1;
            p.v2 = (({$random(seed)} % 4) != 0);   // single about a quarter of the time
            drive_pair(p);
            if (({$random(seed)} % 4) == 0) begin
                repeat (1 + {$random(seed)} % 3) @(posedge clk);
                #1;
            end
        end
        if (!timed_out) begin
            wait_drain();
        end
        if (!timed_out) begin
            repeat (4) @(posedge clk);   // room for any late extra retire
            check_value("expected queue size", 32'(exp_q.size()), 32'd0);
            check_value("retired count", 32'(retired), 32'(accepted));
        end
        end_run();
    end

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module cpu_core (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_fetch_valid,
    input  core_pkg::fetch_pair_t i_fetch,
    output logic                  o_fetch_ready,
    output core_pkg::retire_t     o_retire_a,
    output core_pkg::retire_t     o_retire_b
);

    // buffer to decode
    core_pkg::instr_t      head, next;
    logic                  head_valid, next_valid;
    logic [1:0]            pop_cnt;

    core_pkg::decoded_t    dec_a, dec_b;

    // register file read ports
    logic [`CORE_RADDR_W-1:0] raddr_a1, raddr_a2, raddr_b1, raddr_b2;
    logic [`CORE_XLEN-1:0]    rdata_a1, rdata_a2, rdata_b1, rdata_b2;

    core_pkg::issue_t      issue_a, issue_b;
    core_pkg::retire_t     fwd_a, fwd_b;

    //////////////////////////////
    // front end
    //////////////////////////////

    instr_buffer u_instr_buffer (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch       (i_fetch),
        .o_fetch_ready (o_fetch_ready),
        .o_head        (head),
        .o_head_valid  (head_valid),
        .o_next        (next),
        .o_next_valid  (next_valid),
        .i_pop_cnt     (pop_cnt)
    );

    instr_decode u_decode_a (.i_instr(head), .o_dec(dec_a));
    instr_decode u_decode_b (.i_instr(next), .o_dec(dec_b));

    issue_dispatch u_issue_dispatch (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_dec_a      (dec_a),
        .i_dec_b      (dec_b),
        .i_head_valid (head_valid),
        .i_next_valid (next_valid),
        .o_pop_cnt    (pop_cnt),
        .o_raddr_a1   (raddr_a1),
        .o_raddr_a2   (raddr_a2),
        .o_raddr_b1   (raddr_b1),
        .o_raddr_b2   (raddr_b2),
        .i_rdata_a1   (rdata_a1),
        .i_rdata_a2   (rdata_a2),
        .i_rdata_b1   (rdata_b1),
        .i_rdata_b2   (rdata_b2),
        .i_fwd_a      (fwd_a),
        .i_fwd_b      (fwd_b),
        .o_issue_a    (issue_a),
        .o_issue_b    (issue_b)
    );

    //////////////////////////////
    // back end
    //////////////////////////////

    reg_file u_reg_file (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_raddr_a1 (raddr_a1),
        .i_raddr_a2 (raddr_a2),
        .i_raddr_b1 (raddr_b1),
        .i_raddr_b2 (raddr_b2),
        .o_rdata_a1 (rdata_a1),
        .o_rdata_a2 (rdata_a2),
        .o_rdata_b1 (rdata_b1),
        .o_rdata_b2 (rdata_b2),
        .i_wr_a     (o_retire_a),   // retire records double as write ports
        .i_wr_b     (o_retire_b)
    );

    alu_lane u_lane_a (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_issue  (issue_a),
        .o_fwd    (fwd_a),
        .o_retire (o_retire_a)
    );

    alu_lane u_lane_b (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_issue  (issue_b),
        .o_fwd    (fwd_b),
        .o_retire (o_retire_b)
    );

endmodule

//--- hdl/alu_lane.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module alu_lane (
    input  logic              clk,
    input  logic              i_rst_n,
    input  core_pkg::issue_t  i_issue,
    output core_pkg::retire_t o_fwd,     // same-cycle bypass source
    output core_pkg::retire_t o_retire
);

    logic [`CORE_XLEN-1:0] result;
    logic                  slt_bit;

    assign slt_bit = ($signed(i_issue.a) < $signed(i_issue.b));

    //////////////////////////////
    // execute
    //////////////////////////////

    always_comb begin
        case (i_issue.op)
            core_pkg::OP_ADD,
            core_pkg::OP_ADDI: result = i_issue.a + i_issue.b;
            core_pkg::OP_SUB:  result = i_issue.a - i_issue.b;
            core_pkg::OP_AND:  result = i_issue.a & i_issue.b;
            core_pkg::OP_OR:   result = i_issue.a | i_issue.b;
            core_pkg::OP_XOR:  result = i_issue.a ^ i_issue.b;
            core_pkg::OP_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, slt_bit};
            core_pkg::OP_LUI:  result = i_issue.b << 16;   // raw imm to upper half
            default:           result = '0;
        endcase
    end

    assign o_fwd.valid     = i_issue.valid;
    assign o_fwd.rd        = i_issue.rd;
    assign o_fwd.writes_rd = i_issue.writes_rd;
    assign o_fwd.result    = result;
    assign o_fwd.pc        = i_issue.pc;

    // writeback stage register
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_retire.valid <= 1'b0;
        end else begin
            o_retire <= o_fwd;
        end
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic [`CORE_RADDR_W-1:0] i_raddr_a1,
    input  logic [`CORE_RADDR_W-1:0] i_raddr_a2,
    input  logic [`CORE_RADDR_W-1:0] i_raddr_b1,
    input  logic [`CORE_RADDR_W-1:0] i_raddr_b2,
    output logic [`CORE_XLEN-1:0]    o_rdata_a1,
    output logic [`CORE_XLEN-1:0]    o_rdata_a2,
    output logic [`CORE_XLEN-1:0]    o_rdata_b1,
    output logic [`CORE_XLEN-1:0]    o_rdata_b2,
    input  core_pkg::retire_t        i_wr_a,
    input  core_pkg::retire_t        i_wr_b
);

    localparam int NREG = 1 << `CORE_RADDR_W;

    logic [`CORE_XLEN-1:0] regs_q [NREG];
    logic                  we_a;
    logic                  we_b;

    assign we_a = i_wr_a.valid && i_wr_a.writes_rd && (i_wr_a.rd != '0);
    assign we_b = i_wr_b.valid && i_wr_b.writes_rd && (i_wr_b.rd != '0);

    // port b last, so it wins a same-register collision
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (we_a) regs_q[i_wr_a.rd] <= i_wr_a.result;
            if (we_b) regs_q[i_wr_b.rd] <= i_wr_b.result;
        end
    end

    // same priority on the write-through path
    function automatic logic [`CORE_XLEN-1:0] read_port(
        input logic [`CORE_RADDR_W-1:0] addr
    );
        logic [`CORE_XLEN-1:0] val;
        if (addr == '0)                      val = '0;
        else if (we_b && (i_wr_b.rd == addr)) val = i_wr_b.result;
        else if (we_a && (i_wr_a.rd == addr)) val = i_wr_a.result;
        else                                  val = regs_q[addr];
        return val;
    endfunction

    always_comb begin
        o_rdata_a1 = read_port(i_raddr_a1);
        o_rdata_a2 = read_port(i_raddr_a2);
        o_rdata_b1 = read_port(i_raddr_b1);
        o_rdata_b2 = read_port(i_raddr_b2);
    end

endmodule

//--- hdl/issue_dispatch.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module issue_dispatch (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  core_pkg::decoded_t       i_dec_a,       // buffer head
    input  core_pkg::decoded_t       i_dec_b,       // second oldest
    input  logic                     i_head_valid,
    input  logic                     i_next_valid,
    output logic [1:0]               o_pop_cnt,
    output logic [`CORE_RADDR_W-1:0] o_raddr_a1,
    output logic [`CORE_RADDR_W-1:0] o_raddr_a2,
    output logic [`CORE_RADDR_W-1:0] o_raddr_b1,
    output logic [`CORE_RADDR_W-1:0] o_raddr_b2,
    input  logic [`CORE_XLEN-1:0]    i_rdata_a1,
    input  logic [`CORE_XLEN-1:0]    i_rdata_a2,
    input  logic [`CORE_XLEN-1:0]    i_rdata_b1,
    input  logic [`CORE_XLEN-1:0]    i_rdata_b2,
    input  core_pkg::retire_t        i_fwd_a,
    input  core_pkg::retire_t        i_fwd_b,
    output core_pkg::issue_t         o_issue_a,
    output core_pkg::issue_t         o_issue_b
);

    logic                  raw_hazard;
    logic                  issue_b_ok;
    logic [`CORE_XLEN-1:0] opnd_a1, opnd_a2, opnd_b1, opnd_b2;
    core_pkg::issue_t      issue_a_d, issue_b_d;

    // lane b is younger, so its result shadows lane a's
    function automatic logic [`CORE_XLEN-1:0] pick_operand(
        input logic [`CORE_RADDR_W-1:0] addr,
        input logic [`CORE_XLEN-1:0]    rf_data,
        input core_pkg::retire_t        fwd_a,
        input core_pkg::retire_t        fwd_b
    );
        logic [`CORE_XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (fwd_b.valid && fwd_b.writes_rd && (fwd_b.rd == addr)) begin
            val = fwd_b.result;
        end else if (fwd_a.valid && fwd_a.writes_rd && (fwd_a.rd == addr)) begin
            val = fwd_a.result;
        end else begin
            val = rf_data;   // covers retire stage via write-through
        end
        return val;
    endfunction

    function automatic core_pkg::issue_t build_issue(
        input logic                  valid,
        input core_pkg::decoded_t    dec,
        input logic [`CORE_XLEN-1:0] opnd1,
        input logic [`CORE_XLEN-1:0] opnd2
    );
        core_pkg::issue_t rec;
        rec.valid     = valid;
        rec.op        = dec.op;
        rec.rd        = dec.rd;
        rec.writes_rd = dec.writes_rd;
        rec.a         = opnd1;
        rec.b         = dec.uses_rs2 ? opnd2 : dec.imm;
        rec.pc        = dec.pc;
        return rec;
    endfunction

    //////////////////////////////
    // slot grant
    //////////////////////////////

    assign raw_hazard = i_dec_a.writes_rd &&
                        ((i_dec_a.rd == i_dec_b.rs1) ||
                         (i_dec_b.uses_rs2 && (i_dec_a.rd == i_dec_b.rs2)));

    assign issue_b_ok = i_head_valid && i_next_valid && !raw_hazard;
    assign o_pop_cnt  = !i_head_valid ? 2'd0 : (issue_b_ok ? 2'd2 : 2'd1);

    // operand fetch
    assign o_raddr_a1 = i_dec_a.rs1;
    assign o_raddr_a2 = i_dec_a.rs2;
    assign o_raddr_b1 = i_dec_b.rs1;
    assign o_raddr_b2 = i_dec_b.rs2;

    assign opnd_a1 = pick_operand(o_raddr_a1, i_rdata_a1, i_fwd_a, i_fwd_b);
    assign opnd_a2 = pick_operand(o_raddr_a2, i_rdata_a2, i_fwd_a, i_fwd_b);
    assign opnd_b1 = pick_operand(o_raddr_b1, i_rdata_b1, i_fwd_a, i_fwd_b);
    assign opnd_b2 = pick_operand(o_raddr_b2, i_rdata_b2, i_fwd_a, i_fwd_b);

    assign issue_a_d = build_issue(i_head_valid, i_dec_a, opnd_a1, opnd_a2);
    assign issue_b_d = build_issue(issue_b_ok, i_dec_b, opnd_b1, opnd_b2);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_issue_a.valid <= 1'b0;
            o_issue_b.valid <= 1'b0;
        end else begin
            o_issue_a <= issue_a_d;
            o_issue_b <= issue_b_d;
        end
    end

    // a second candidate only ever sits behind a valid head
    lane_order: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_next_valid |-> i_head_valid);

endmodule

//--- hdl/instr_decode.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module instr_decode (
    input  core_pkg::instr_t   i_instr,
    output core_pkg::decoded_t o_dec
);

    logic [5:0]     opc;
    logic [15:0]    imm16;
    core_pkg::op_e  op;

    assign opc   = i_instr.ir[31:26];
    assign imm16 = i_instr.ir[15:0];

    // unknown codes retire as nops
    always_comb begin
        case (opc)
            core_pkg::OP_ADD,
            core_pkg::OP_SUB,
            core_pkg::OP_AND,
            core_pkg::OP_OR,
            core_pkg::OP_XOR,
            core_pkg::OP_SLT,
            core_pkg::OP_ADDI,
            core_pkg::OP_LUI: op = core_pkg::op_e'(opc);
            default:          op = core_pkg::OP_NOP;
        endcase
    end

    //////////////////////////////
    // field extraction
    //////////////////////////////

    assign o_dec.op  = op;
    assign o_dec.rd  = i_instr.ir[25:21];
    assign o_dec.rs1 = i_instr.ir[20:16];
    assign o_dec.rs2 = i_instr.ir[15:11];   // overlaps imm, only read for r-type
    assign o_dec.pc  = i_instr.pc;

    // addi sign extends, lui keeps the raw 16 bits and the lane shifts
    assign o_dec.imm = (op == core_pkg::OP_ADDI) ?
                       {{(`CORE_XLEN-16){imm16[15]}}, imm16} :
                       {{(`CORE_XLEN-16){1'b0}}, imm16};

    assign o_dec.uses_rs2  = (op != core_pkg::OP_ADDI) && (op != core_pkg::OP_LUI);
    assign o_dec.writes_rd = (op != core_pkg::OP_NOP) && (i_instr.ir[25:21] != 5'd0);

endmodule

//--- hdl/instr_buffer.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module instr_buffer (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_fetch_valid,
    input  core_pkg::fetch_pair_t i_fetch,
    output logic                  o_fetch_ready,
    output core_pkg::instr_t      o_head,
    output logic                  o_head_valid,
    output core_pkg::instr_t      o_next,
    output logic                  o_next_valid,
    input  logic [1:0]            i_pop_cnt
);

    localparam int DEPTH = `CORE_IBUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [`CORE_XLEN-1:0] PC_STEP = 4;

    core_pkg::instr_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] rd_ptr_nx;    // slot behind the head
    logic [CNT_W-1:0] count_q;

    logic             fetch_fire;
    logic [1:0]       push_cnt;
    core_pkg::instr_t first_in;
    core_pkg::instr_t second_in;

    // pointer advance with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_step(
        input logic [PTR_W-1:0] ptr,
        input logic [1:0]       n
    );
        logic [PTR_W:0] sum;
        sum = {1'b0, ptr} + {{(PTR_W-1){1'b0}}, n};
        if (sum >= (PTR_W+1)'(DEPTH)) begin
            sum = sum - (PTR_W+1)'(DEPTH);
        end
        return sum[PTR_W-1:0];
    endfunction

    //////////////////////////////
    // push side
    //////////////////////////////

    assign o_fetch_ready = (count_q <= CNT_W'(DEPTH - 2));  // room for a whole pair
    assign fetch_fire    = i_fetch_valid && o_fetch_ready;
    assign push_cnt      = fetch_fire ? ({1'b0, i_fetch.v1} + {1'b0, i_fetch.v2}) : 2'd0;

    // a lone v2 still lands in the first free slot
    assign first_in.pc  = i_fetch.v1 ? i_fetch.pc  : i_fetch.pc + PC_STEP;
    assign first_in.ir  = i_fetch.v1 ? i_fetch.ir1 : i_fetch.ir2;
    assign second_in.pc = i_fetch.pc + PC_STEP;
    assign second_in.ir = i_fetch.ir2;

    always_ff @(posedge clk) begin
        if (push_cnt != 2'd0) begin
            mem[wr_ptr_q] <= first_in;
        end
        if (push_cnt == 2'd2) begin
            mem[ptr_step(wr_ptr_q, 2'd1)] <= second_in;
        end
    end

    //////////////////////////////
    // pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= ptr_step(wr_ptr_q, push_cnt);
            rd_ptr_q <= ptr_step(rd_ptr_q, i_pop_cnt);
            count_q  <= count_q + CNT_W'(push_cnt) - CNT_W'(i_pop_cnt);
        end
    end

    // pop side, two oldest entries
    assign rd_ptr_nx    = ptr_step(rd_ptr_q, 2'd1);
    assign o_head       = mem[rd_ptr_q];
    assign o_next       = mem[rd_ptr_nx];
    assign o_head_valid = (count_q >= CNT_W'(1));
    assign o_next_valid = (count_q >= CNT_W'(2));

    // dispatch must never take more than is offered
    pop_in_range: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_pop_cnt <= ({1'b0, o_head_valid} + {1'b0, o_next_valid}));

endmodule

//--- hdl/core_pkg.sv
`include "core_consts.svh"

package core_pkg;

    // opcode field, bits 31:26 of the instruction word
    typedef enum logic [5:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_XOR  = 6'd5,
        OP_SLT  = 6'd6,  // signed compare
        OP_ADDI = 6'd7,
        OP_LUI  = 6'd8
    } op_e;

    //////////////////////////////
    // pipeline records
    //////////////////////////////

    typedef struct packed {
        logic [`CORE_XLEN-1:0]    pc;   // pc of ir1, ir2 sits at pc + 4
        logic [`CORE_XLEN-1:0]    ir1;
        logic [`CORE_XLEN-1:0]    ir2;
        logic                     v1;
        logic                     v2;
    } fetch_pair_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]    pc;
        logic [`CORE_XLEN-1:0]    ir;
    } instr_t;

    typedef struct packed {
        op_e                      op;
        logic [`CORE_RADDR_W-1:0] rd;
        logic [`CORE_RADDR_W-1:0] rs1;
        logic [`CORE_RADDR_W-1:0] rs2;
        logic [`CORE_XLEN-1:0]    imm;       // already extended
        logic                     uses_rs2;
        logic                     writes_rd;
        logic [`CORE_XLEN-1:0]    pc;
    } decoded_t;

    typedef struct packed {
        logic                     valid;
        op_e                      op;
        logic [`CORE_RADDR_W-1:0] rd;
        logic                     writes_rd;
        logic [`CORE_XLEN-1:0]    a;
        logic [`CORE_XLEN-1:0]    b;         // rs2 value or immediate
        logic [`CORE_XLEN-1:0]    pc;
    } issue_t;

    typedef struct packed {
        logic                     valid;
        logic [`CORE_RADDR_W-1:0] rd;
        logic                     writes_rd;
        logic [`CORE_XLEN-1:0]    result;
        logic [`CORE_XLEN-1:0]    pc;
    } retire_t;

endpackage

//--- hdl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

//////////////////////////////
// core sizing
//////////////////////////////

// data path and instruction word width
`define CORE_XLEN 32

// register address width, 32 architectural registers
`define CORE_RADDR_W 5

// instruction buffer slots
// keep even and >= 4 so a full pair always fits once ready is high
`define CORE_IBUF_DEPTH 8

`endif
